// ==== files.f ====
+incdir+.
axi_mstr_pkg.sv
cfg_reg_decode.sv
axi_mstr_fsm.sv
cmd_result.sv
axi_mstr_top.sv
tb_axi_mstr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the axi master testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_axi_mstr

out="$(./obj_dir/Vtb_axi_mstr || true)"
echo "$out"

if grep -qx "STATUS: PASS" <<< "$out"; then
  exit 0
else
  exit 1
fi

// ==== tb_axi_mstr_tests.svh ====
// directed tests for the axi master, included inside tb_axi_mstr
// register bus access, polling for done and one task per behavior

`ifndef TB_AXI_MSTR_TESTS_SVH
`define TB_AXI_MSTR_TESTS_SVH

// --------------------------------------------------
// register bus
// --------------------------------------------------

// one request pulse, then wait for ack; the ack must come 2 cycles later
task automatic cfg_access(input logic is_wr, input logic [CFG_ADDR_W-1:0] addr,
                          input logic [31:0] data, output logic [31:0] rd_word);
  int n;
  @(posedge aclk);
  cfg_wr    <= is_wr;
  cfg_rd    <= ~is_wr;
  cfg_addr  <= addr;
  cfg_wdata <= data;
  @(posedge aclk);
  cfg_wr <= 1'b0;
  cfg_rd <= 1'b0;
  n = 1;
  @(negedge aclk);
  while (!cfg_ack) begin
    @(negedge aclk);
    n++;
    assert (n <= WAIT_LIMIT) else report_error("cfg_ack never came after a request");
  end
  check_val("cfg_ack latency", 512'(n), 512'(2));
  rd_word = cfg_rdata;  // valid in the ack cycle
endtask

task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] data);
  logic [31:0] unused;
  cfg_access(1'b1, addr, data, unused);
endtask

task automatic cfg_read_check(input string name, input logic [CFG_ADDR_W-1:0] addr,
                              input logic [31:0] exp);
  logic [31:0] got;
  cfg_access(1'b0, addr, 32'h0, got);
  check_val(name, 512'(got), 512'(exp));
endtask

// poll ccr until done reads back set
task automatic wait_done();
  logic [31:0] ccr;
  int          n;
  n = 0;
  cfg_access(1'b0, CCR_OFFS, 32'h0, ccr);
  while (!ccr[1]) begin
    n++;
    assert (n <= WAIT_LIMIT) else report_error("done never set after go");
    cfg_access(1'b0, CCR_OFFS, 32'h0, ccr);
  end
endtask

// the 32 bit word sitting at byte offset off of a beat
function automatic logic [31:0] lane_word(input logic [DATA_W-1:0] beat, input int off);
  logic [31:0] w;
  for (int i = 0; i < 4; i++)
    w[8*i +: 8] = beat[8*(off+i) +: 8];
  return w;
endfunction

// --------------------------------------------------
// command helpers
// --------------------------------------------------
task automatic run_write(input logic [31:0] hi, input logic [31:0] lo, input logic [31:0] word);
  logic [DATA_W-1:0]   exp_data;
  logic [DATA_W/8-1:0] exp_strb;
  int                  off;
  off      = int'(lo[5:0]);
  exp_data = '0;
  exp_strb = '0;
  for (int i = 0; i < 4; i++) begin
    exp_data[8*(off+i) +: 8] = word[8*i +: 8];  // byte i of the word lands at off+i
    exp_strb[off+i]          = 1'b1;
  end
  cfg_write(CAHR_OFFS, hi);
  cfg_write(CALR_OFFS, lo);
  cfg_write(CWDR_OFFS, word);
  cfg_write(CCR_OFFS, 32'h1);  // go, write, done cleared
  wait_done();
  check_val("awaddr", 512'(last_awaddr), 512'({hi, lo}));
  check_val("wdata", last_wdata, exp_data);
  check_val("wstrb", 512'(last_wstrb), 512'(exp_strb));
  cfg_read_check("ccr", CCR_OFFS, 32'h2);  // done only
endtask

task automatic run_read(input logic [31:0] hi, input logic [31:0] lo, input logic [31:0] exp);
  cfg_write(CAHR_OFFS, hi);
  cfg_write(CALR_OFFS, lo);
  cfg_write(CCR_OFFS, 32'h5);  // go, read
  wait_done();
  check_val("araddr", 512'(last_araddr), 512'({hi, lo}));
  cfg_read_check("crdr", CRDR_OFFS, exp);
  cfg_read_check("ccr", CCR_OFFS, 32'h6);  // rd_wrb kept, done set
endtask

// --------------------------------------------------
// tests
// --------------------------------------------------
task automatic test_reset_state();
  logic [CFG_ADDR_W-1:0] offs [5];
  offs = '{CCR_OFFS, CAHR_OFFS, CALR_OFFS, CWDR_OFFS, CRDR_OFFS};
  @(negedge aclk);
  assert (!(awvalid || wvalid || arvalid || bready || rready || cfg_ack)) else
    report_error("a valid, ready or ack is active right after reset");
  foreach (offs[k])
    cfg_read_check($sformatf("cfg_rdata at 'h%02h", offs[k]), offs[k], 32'h0);
  cfg_read_check("cfg_rdata at 'h20", 8'h20, 32'hffff_ffff);  // unmapped
endtask

task automatic test_reg_access();
  logic [CFG_ADDR_W-1:0] offs [4];
  logic [31:0]           vals [4];
  offs = '{CAHR_OFFS, CALR_OFFS, CWDR_OFFS, CRDR_OFFS};
  foreach (offs[k]) begin
    rand_bits(32, vals[k]);
    cfg_write(offs[k], vals[k]);
  end
  // read back only after all writes, catches crosstalk
  foreach (offs[k])
    cfg_read_check($sformatf("cfg_rdata at 'h%02h", offs[k]), offs[k], vals[k]);
endtask

task automatic test_write_cmds();
  int          offs [5];
  logic [31:0] hi;
  logic [31:0] word;
  logic [31:0] r;
  offs = '{0, 7, 13, 32, 60};
  foreach (offs[k]) begin
    rand_bits(32, hi);
    rand_bits(32, word);
    rand_bits(32, r);
    run_write(hi, {r[31:10], 1'b0, r[8:6], 6'(offs[k])}, word);  // beats 0..7
  end
endtask

task automatic test_read_cmds();
  int          offs [4];
  logic [31:0] hi;
  logic [31:0] lo;
  logic [31:0] r;
  offs = '{4, 21, 44, 60};
  foreach (offs[k]) begin
    rand_bits(32, hi);
    rand_bits(32, r);
    lo = {r[31:10], 1'b1, r[8:6], 6'(offs[k])};  // beats 8..15 keep their fill
    run_read(hi, lo, lane_word(fill_beat(lo[9:6]), offs[k]));
  end
endtask

task automatic test_write_then_read();
  int          offs [2];
  logic [31:0] hi;
  logic [31:0] lo;
  logic [31:0] word;
  logic [31:0] r;
  offs = '{24, 37};
  foreach (offs[k]) begin
    rand_bits(32, hi);
    rand_bits(32, word);
    rand_bits(32, r);
    lo = {r[31:10], 1'b0, r[8:6], 6'(offs[k])};
    run_write(hi, lo, word);
    run_read(hi, lo, word);
  end
endtask

task automatic test_go_while_done();
  logic [31:0] hi;
  logic [31:0] word;
  logic [31:0] r;
  rand_bits(32, hi);
  rand_bits(32, word);
  rand_bits(32, r);
  cfg_read_check("ccr", CCR_OFFS, 32'h6);  // left set by the last read
  cfg_write(CCR_OFFS, 32'h3);              // go with done still set
  cfg_read_check("ccr", CCR_OFFS, 32'h3);
  repeat (20) begin
    @(negedge aclk);
    assert (!(awvalid || wvalid || arvalid)) else
      report_error("a command started while done was still set");
  end
  // ccr write with go=1 and done=0 releases it
  run_write(hi, {r[31:10], 1'b0, r[8:6], 6'd52}, word);
endtask

`endif

// ==== tb_axi_mstr.sv ====
// testbench for the register driven axi master
// the host side is driven from the directed test tasks in the included header,
// the axi side is answered by a beat wide memory model with random delays
// run through files.f, top module tb_axi_mstr

`timescale 1ns/1ps

module tb_axi_mstr;

  import axi_mstr_pkg::*;

  localparam int DATA_W     = 512;
  localparam int MEM_BEATS  = 16;  // 1 KiB behind the slave, index addr[9:6]
  localparam int WAIT_LIMIT = 40;  // bound for any single wait loop

  logic                  aclk;
  logic                  rst_n;
  logic                  cfg_wr;
  logic                  cfg_rd;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [31:0]           cfg_wdata;
  logic                  cfg_ack;
  logic [31:0]           cfg_rdata;
  logic                  awvalid;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awready;
  logic                  wvalid;
  logic [DATA_W-1:0]     wdata;
  logic [DATA_W/8-1:0]   wstrb;
  logic                  wready;
  logic                  bvalid;
  logic                  bready;
  logic                  arvalid;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arready;
  logic                  rvalid;
  logic [DATA_W-1:0]     rdata;
  logic                  rready;

  logic [DATA_W-1:0]     mem [MEM_BEATS];  // slave memory, one beat per entry
  logic [AXI_ADDR_W-1:0] last_awaddr;      // what the slave accepted last
  logic [AXI_ADDR_W-1:0] last_araddr;
  logic [DATA_W-1:0]     last_wdata;
  logic [DATA_W/8-1:0]   last_wstrb;
  logic [31:0]           lfsr_q = 32'h147e;

  axi_mstr_top #(.DATA_W(DATA_W)) DUT (.*);

  initial begin : clk_gen
    aclk = 1'b0;
    forever #5 aclk = ~aclk;  // 100 MHz
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  // one lfsr step per bit taken, newest bit at the lsb
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // known content, word j of beat b
  function automatic logic [31:0] fill_word(input logic [3:0] b, input int j);
    logic [7:0] w;
    w = {b, 4'(j)};
    return {w, ~w, w ^ 8'h3c, 8'h5a};
  endfunction

  function automatic logic [DATA_W-1:0] fill_beat(input logic [3:0] b);
    logic [DATA_W-1:0] beat;
    for (int j = 0; j < DATA_W / 32; j++)
      beat[32*j +: 32] = fill_word(b, j);
    return beat;
  endfunction

  task automatic report_error(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
    assert (got === exp) else
      report_error($sformatf("FAIL at %0d ns: %s = 'h%0h, expected 'h%0h",
                             $time, name, got, exp));
  endtask

  // --------------------------------------------------
  // axi slave model
  // --------------------------------------------------
  task automatic slave_delay();
    logic [31:0] r;
    rand_bits(2, r);
    repeat (r[1:0]) @(posedge aclk);  // 0..3 cycles
  endtask

  task automatic serve_write();
    int n;
    slave_delay();
    @(posedge aclk);
    awready <= 1'b1;
    @(negedge aclk);
    last_awaddr = awaddr;
    @(posedge aclk);
    awready <= 1'b0;  // aw taken on this edge
    n = 0;
    @(negedge aclk);
    while (!wvalid) begin
      @(negedge aclk);
      n++;
      assert (n <= WAIT_LIMIT) else report_error("wvalid never followed the aw handshake");
    end
    slave_delay();
    @(posedge aclk);
    wready <= 1'b1;
    @(negedge aclk);
    last_wdata = wdata;
    last_wstrb = wstrb;
    @(posedge aclk);
    wready <= 1'b0;
    for (int i = 0; i < DATA_W / 8; i++)
      if (last_wstrb[i]) mem[last_awaddr[9:6]][8*i +: 8] = last_wdata[8*i +: 8];
    slave_delay();
    @(posedge aclk);
    bvalid <= 1'b1;
    @(posedge aclk);
    bvalid <= 1'b0;  // bready is up all through WR_RESP
  endtask

  task automatic serve_read();
    slave_delay();
    @(posedge aclk);
    arready <= 1'b1;
    @(negedge aclk);
    last_araddr = araddr;
    @(posedge aclk);
    arready <= 1'b0;
    slave_delay();
    @(posedge aclk);
    rvalid <= 1'b1;
    rdata  <= mem[last_araddr[9:6]];
    @(posedge aclk);
    rvalid <= 1'b0;
    rdata  <= '0;
  endtask

  initial begin : axi_slave
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    for (int b = 0; b < MEM_BEATS; b++)
      mem[b] = fill_beat(4'(b));
    forever begin
      @(negedge aclk);
      if (rst_n && awvalid)      serve_write();
      else if (rst_n && arvalid) serve_read();
    end
  end

  `include "tb_axi_mstr_tests.svh"

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin : test_seq
    rst_n     = 1'b0;
    cfg_wr    = 1'b0;
    cfg_rd    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (8) @(posedge aclk);
    rst_n <= 1'b1;
    @(posedge aclk);
    test_reset_state();
    test_reg_access();
    test_write_cmds();
    test_read_cmds();
    test_write_then_read();
    test_go_while_done();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== axi_mstr_top.sv ====
// top of the register driven single-command axi master
// host programs address, data and ccr over the cfg bus, the engine then
// runs one 4 byte axi write or read; id/len/size/last are tied off outside

`timescale 1ns/1ps

module axi_mstr_top #(
  parameter int DATA_W = 512
) (
  input  logic                                    aclk,
  input  logic                                    rst_n,
  // register bus
  input  logic                                    cfg_wr,
  input  logic                                    cfg_rd,
  input  logic [axi_mstr_pkg::CFG_ADDR_W-1:0]     cfg_addr,
  input  logic [31:0]                             cfg_wdata,
  output logic                                    cfg_ack,
  output logic [31:0]                             cfg_rdata,
  // axi master
  output logic                                    awvalid,
  output logic [axi_mstr_pkg::AXI_ADDR_W-1:0]     awaddr,
  input  logic                                    awready,
  output logic                                    wvalid,
  output logic [DATA_W-1:0]                       wdata,
  output logic [axi_mstr_pkg::strb_w(DATA_W)-1:0] wstrb,
  input  logic                                    wready,
  input  logic                                    bvalid,
  output logic                                    bready,
  output logic                                    arvalid,
  output logic [axi_mstr_pkg::AXI_ADDR_W-1:0]     araddr,
  input  logic                                    arready,
  input  logic                                    rvalid,
  input  logic [DATA_W-1:0]                       rdata,
  output logic                                    rready
);

  import axi_mstr_pkg::*;

  // --------------------------------------------------
  // decode <-> fsm <-> result
  // --------------------------------------------------
  logic                  cmd_go;
  logic                  cmd_rd_wrb;
  logic [AXI_ADDR_W-1:0] cmd_addr;
  logic [31:0]           cmd_wr_data;
  logic                  cmd_done;
  logic [31:0]           cmd_rd_data;
  logic                  sm_idle;
  logic                  ccr_wr;
  logic                  crdr_wr;
  logic [31:0]           wr_word;
  logic                  wr_done_beat;
  logic                  rd_beat;

  cfg_reg_decode u_decode (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .cfg_wr      (cfg_wr),
    .cfg_rd      (cfg_rd),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_ack     (cfg_ack),
    .cfg_rdata   (cfg_rdata),
    .sm_idle     (sm_idle),
    .cmd_done    (cmd_done),
    .cmd_rd_data (cmd_rd_data),
    .cmd_go      (cmd_go),
    .cmd_rd_wrb  (cmd_rd_wrb),
    .cmd_addr    (cmd_addr),
    .cmd_wr_data (cmd_wr_data),
    .ccr_wr      (ccr_wr),
    .crdr_wr     (crdr_wr),
    .wr_word     (wr_word)
  );

  axi_mstr_fsm #(.DATA_W(DATA_W)) u_fsm (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .cmd_go       (cmd_go),
    .cmd_done     (cmd_done),
    .cmd_rd_wrb   (cmd_rd_wrb),
    .cmd_addr     (cmd_addr),
    .cmd_wr_data  (cmd_wr_data),
    .awvalid      (awvalid),
    .awaddr       (awaddr),
    .awready      (awready),
    .wvalid       (wvalid),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wready       (wready),
    .bvalid       (bvalid),
    .bready       (bready),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .arready      (arready),
    .rvalid       (rvalid),
    .rready       (rready),
    .sm_idle      (sm_idle),
    .wr_done_beat (wr_done_beat),
    .rd_beat      (rd_beat)
  );

  cmd_result #(.DATA_W(DATA_W)) u_result (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .ccr_wr       (ccr_wr),
    .crdr_wr      (crdr_wr),
    .wr_word      (wr_word),
    .wr_done_beat (wr_done_beat),
    .rd_beat      (rd_beat),
    .rdata        (rdata),
    .lane_addr    (cmd_addr[5:0]),  // byte lane of the word
    .cmd_done     (cmd_done),
    .cmd_rd_data  (cmd_rd_data)
  );

endmodule

// ==== cmd_result.sv ====
// command result registers: done flag and read data (crdr)
// done is set by the final handshake of either command and
// can be loaded by software through ccr, crdr likewise

`timescale 1ns/1ps

module cmd_result #(
  parameter int DATA_W = 512
) (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic              ccr_wr,        // ccr write strobe
  input  logic              crdr_wr,       // crdr write strobe
  input  logic [31:0]       wr_word,       // captured bus word
  input  logic              wr_done_beat,  // b handshake
  input  logic              rd_beat,       // r handshake
  input  logic [DATA_W-1:0] rdata,
  input  logic [5:0]        lane_addr,     // low address bits
  output logic              cmd_done,
  output logic [31:0]       cmd_rd_data
);

  import axi_mstr_pkg::*;

  localparam int LANE_W = lane_w(DATA_W);

  ccr_word_u   wr_ccr;
  logic [DATA_W-1:0] rd_shift;  // beat moved down so the word sits at bit 0

  assign wr_ccr = wr_word;

  // --------------------------------------------------
  // done flag
  // --------------------------------------------------
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_done <= 1'b0;
    end else if (ccr_wr) begin
      cmd_done <= wr_ccr.ctl.done;  // software may clear or set
    end else if (wr_done_beat || rd_beat) begin
      cmd_done <= 1'b1;
    end
  end

  // --------------------------------------------------
  // read data, lane extraction
  // --------------------------------------------------
  assign rd_shift = rdata >> {lane_addr[LANE_W-1:0], 3'b000};

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_rd_data <= '0;
    end else if (crdr_wr) begin
      cmd_rd_data <= wr_word;
    end else if (rd_beat) begin
      cmd_rd_data <= rd_shift[31:0];  // only the accepted beat
    end
  end

  // a new command only starts with done clear
  a_done_clear : assert property (@(posedge aclk) disable iff (!rst_n)
    (wr_done_beat || rd_beat) |-> !cmd_done);

endmodule

// ==== axi_mstr_fsm.sv ====
// axi master sequencer, one single-beat 4 byte command per go
// write path goes aw -> w -> b, read path ar -> r
// valids and readies decode straight from the state register

`timescale 1ns/1ps

module axi_mstr_fsm #(
  parameter int DATA_W = 512
) (
  input  logic                                      aclk,
  input  logic                                      rst_n,
  input  logic                                      cmd_go,
  input  logic                                      cmd_done,
  input  logic                                      cmd_rd_wrb,
  input  logic [axi_mstr_pkg::AXI_ADDR_W-1:0]       cmd_addr,
  input  logic [31:0]                               cmd_wr_data,
  // write address
  output logic                                      awvalid,
  output logic [axi_mstr_pkg::AXI_ADDR_W-1:0]       awaddr,
  input  logic                                      awready,
  // write data
  output logic                                      wvalid,
  output logic [DATA_W-1:0]                         wdata,
  output logic [axi_mstr_pkg::strb_w(DATA_W)-1:0]   wstrb,
  input  logic                                      wready,
  // write response
  input  logic                                      bvalid,
  output logic                                      bready,
  // read address
  output logic                                      arvalid,
  output logic [axi_mstr_pkg::AXI_ADDR_W-1:0]       araddr,
  input  logic                                      arready,
  // read data
  input  logic                                      rvalid,
  output logic                                      rready,
  // towards decode / result
  output logic                                      sm_idle,
  output logic                                      wr_done_beat,
  output logic                                      rd_beat
);

  import axi_mstr_pkg::*;

  localparam int STRB_W = strb_w(DATA_W);
  localparam int LANE_W = lane_w(DATA_W);  // 6 for a 512 bit beat

  mstr_state_e       state_q;
  mstr_state_e       state_ns;
  logic [LANE_W-1:0] lane;  // byte offset of the word in the beat

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb begin
    state_ns = state_q;  // back-pressure just holds
    case (state_q)
      IDLE: begin
        if (cmd_go && !cmd_done)
          state_ns = cmd_rd_wrb ? RD : WR;
      end
      WR:      if (awready) state_ns = WR_DATA;
      WR_DATA: if (wready)  state_ns = WR_RESP;
      WR_RESP: if (bvalid)  state_ns = IDLE;  // bresp ignored
      RD:      if (arready) state_ns = RD_DATA;
      RD_DATA: if (rvalid)  state_ns = IDLE;  // rresp ignored
      default: state_ns = IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) state_q <= IDLE;
    else        state_q <= state_ns;
  end

  // --------------------------------------------------
  // axi outputs
  // --------------------------------------------------
  assign sm_idle = (state_q == IDLE);
  assign awvalid = (state_q == WR);
  assign wvalid  = (state_q == WR_DATA);
  assign bready  = (state_q == WR_RESP);
  assign arvalid = (state_q == RD);
  assign rready  = (state_q == RD_DATA);

  assign awaddr = cmd_addr;  // same address both ways
  assign araddr = cmd_addr;

  // word and 4 strobe bits moved up to the lane
  // lanes above 60 lose the top bytes off the end of the beat
  assign lane  = cmd_addr[LANE_W-1:0];
  assign wdata = {{(DATA_W-32){1'b0}}, cmd_wr_data} << {lane, 3'b000};
  assign wstrb = {{(STRB_W-4){1'b0}}, 4'hF} << lane;

  // completion pulses, one per command
  assign wr_done_beat = bready & bvalid;
  assign rd_beat      = rready & rvalid;

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  a_aw_hold : assert property (@(posedge aclk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid);
  a_w_hold : assert property (@(posedge aclk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid);
  a_ar_hold : assert property (@(posedge aclk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid);
  a_one_valid : assert property (@(posedge aclk) disable iff (!rst_n)
    $onehot0({awvalid, wvalid, arvalid}));

endmodule

// ==== cfg_reg_decode.sv ====
// register bus front end of the axi master
// stretches each wr/rd request until ack, owns the command registers
// and returns readback data in the ack cycle (2 cycles after the request)

`timescale 1ns/1ps

module cfg_reg_decode (
  input  logic                                aclk,
  input  logic                                rst_n,
  input  logic                                cfg_wr,       // one-cycle pulse
  input  logic                                cfg_rd,       // one-cycle pulse
  input  logic [axi_mstr_pkg::CFG_ADDR_W-1:0] cfg_addr,
  input  logic [31:0]                         cfg_wdata,
  output logic                                cfg_ack,
  output logic [31:0]                         cfg_rdata,
  input  logic                                sm_idle,
  input  logic                                cmd_done,
  input  logic [31:0]                         cmd_rd_data,
  output logic                                cmd_go,
  output logic                                cmd_rd_wrb,
  output logic [axi_mstr_pkg::AXI_ADDR_W-1:0] cmd_addr,
  output logic [31:0]                         cmd_wr_data,
  output logic                                ccr_wr,       // strobes towards result block
  output logic                                crdr_wr,
  output logic [31:0]                         wr_word
);

  import axi_mstr_pkg::*;

  logic                  wr_stretch;
  logic                  rd_stretch;
  logic [CFG_ADDR_W-1:0] addr_q;       // captured offset
  logic [CFG_DATA_W-1:0] wdata_q;      // captured write word
  logic                  reg_wr;       // register write edge, same edge ack rises
  ccr_word_u             wr_ccr;       // control view of the captured word
  ccr_word_u             rd_ccr;       // ccr as it reads back
  logic [31:0]           addr_hi_q;
  logic [31:0]           addr_lo_q;

  // --------------------------------------------------
  // request stretch and ack
  // --------------------------------------------------
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_stretch <= 1'b0;
      rd_stretch <= 1'b0;
      addr_q     <= '0;
      wdata_q    <= '0;
    end else begin
      wr_stretch <= cfg_wr | (wr_stretch & ~cfg_ack);  // held until ack
      rd_stretch <= cfg_rd | (rd_stretch & ~cfg_ack);
      if (cfg_wr | cfg_rd) begin
        addr_q  <= cfg_addr;
        wdata_q <= cfg_wdata;
      end
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) cfg_ack <= 1'b0;
    else        cfg_ack <= (wr_stretch | rd_stretch) & ~cfg_ack;  // single pulse
  end

  assign reg_wr  = wr_stretch & ~cfg_ack;
  assign wr_ccr  = wdata_q;
  assign ccr_wr  = reg_wr & (addr_q == CCR_OFFS);
  assign crdr_wr = reg_wr & (addr_q == CRDR_OFFS);
  assign wr_word = wdata_q;  // done bit and crdr load live in cmd_result

  // --------------------------------------------------
  // command registers
  // --------------------------------------------------
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_go      <= 1'b0;
      cmd_rd_wrb  <= 1'b0;
      addr_hi_q   <= '0;
      addr_lo_q   <= '0;
      cmd_wr_data <= '0;
    end else begin
      if (ccr_wr) begin
        cmd_go     <= wr_ccr.ctl.go;
        cmd_rd_wrb <= wr_ccr.ctl.rd_wrb;
      end else begin
        cmd_go <= cmd_go & sm_idle;  // dropped once the fsm has left idle
      end
      if (reg_wr && addr_q == CAHR_OFFS) addr_hi_q   <= wdata_q;
      if (reg_wr && addr_q == CALR_OFFS) addr_lo_q   <= wdata_q;
      if (reg_wr && addr_q == CWDR_OFFS) cmd_wr_data <= wdata_q;
    end
  end

  assign cmd_addr = {addr_hi_q, addr_lo_q};

  // --------------------------------------------------
  // readback mux, refreshed every cycle
  // --------------------------------------------------
  always_comb begin
    rd_ccr            = '0;
    rd_ccr.ctl.rd_wrb = cmd_rd_wrb;
    rd_ccr.ctl.done   = cmd_done;
    rd_ccr.ctl.go     = cmd_go;
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_rdata <= '0;
    end else begin
      case (addr_q)
        CCR_OFFS:  cfg_rdata <= rd_ccr.raw;
        CAHR_OFFS: cfg_rdata <= addr_hi_q;
        CALR_OFFS: cfg_rdata <= addr_lo_q;
        CWDR_OFFS: cfg_rdata <= cmd_wr_data;
        CRDR_OFFS: cfg_rdata <= cmd_rd_data;
        default:   cfg_rdata <= CFG_UNMAPPED_DATA;  // unknown offset
      endcase
    end
  end

  // host side protocol
  a_ack_single : assert property (@(posedge aclk) disable iff (!rst_n)
    cfg_ack |=> !cfg_ack);
  a_no_wr_rd : assert property (@(posedge aclk) disable iff (!rst_n)
    !(cfg_wr && cfg_rd));

endmodule

// ==== axi_mstr_pkg.sv ====
// shared definitions for the single-command axi master
// register map, fsm state encoding, ccr word layout and width helpers
// imported by the decode, fsm, result and top modules

package axi_mstr_pkg;

  // --------------------------------------------------
  // register bus
  // --------------------------------------------------
  localparam int CFG_ADDR_W = 8;   // low offset bits only, upper bits decoded upstream
  localparam int CFG_DATA_W = 32;

  localparam logic [CFG_ADDR_W-1:0] CCR_OFFS  = 8'h00;  // control: rd_wrb / done / go
  localparam logic [CFG_ADDR_W-1:0] CAHR_OFFS = 8'h04;  // address high
  localparam logic [CFG_ADDR_W-1:0] CALR_OFFS = 8'h08;  // address low
  localparam logic [CFG_ADDR_W-1:0] CWDR_OFFS = 8'h0C;  // write data
  localparam logic [CFG_ADDR_W-1:0] CRDR_OFFS = 8'h10;  // read data

  localparam logic [CFG_DATA_W-1:0] CFG_UNMAPPED_DATA = 32'hffff_ffff;

  // --------------------------------------------------
  // axi side
  // --------------------------------------------------
  localparam int AXI_ADDR_W = 64;

  // master sequence, one step per handshake
  typedef enum logic [2:0] {
    IDLE    = 3'd0,  // waiting for go
    WR      = 3'd1,  // awvalid up
    WR_DATA = 3'd2,  // wvalid up
    WR_RESP = 3'd3,  // bready up
    RD      = 3'd4,  // arvalid up
    RD_DATA = 3'd5   // rready up
  } mstr_state_e;

  // ccr seen either as a plain bus word or as its control fields
  typedef union packed {
    logic [CFG_DATA_W-1:0] raw;
    struct packed {
      logic [CFG_DATA_W-4:0] rsvd;    // reads as zero
      logic                  rd_wrb;  // 1 = read, 0 = write
      logic                  done;
      logic                  go;
    } ctl;
  } ccr_word_u;

  // --------------------------------------------------
  // width helpers
  // --------------------------------------------------

  // bytes per data beat, one strobe bit each
  function automatic int strb_w(input int data_w);
    return data_w / 8;
  endfunction

  // bits needed to pick a byte lane inside a beat
  function automatic int lane_w(input int data_w);
    return $clog2(data_w / 8);
  endfunction

endpackage
